//--- hdl/load_unit_consts.svh
// ----------------------------------------------------------
// load unit widths
// address, data, cache index/tag, byte offset and
// transaction id widths shared by all load unit blocks
// ----------------------------------------------------------
`ifndef LOAD_UNIT_CONSTS_SVH
`define LOAD_UNIT_CONSTS_SVH

// virtual and physical address widths of the core
`define LU_VADDR_W 64
`define LU_PADDR_W 56

// the data cache returns one doubleword per response
`define LU_DATA_W 64

// the index is the untranslated low part of the virtual address
`define LU_INDEX_W 12
// the tag is physical address bits 55 down to 12
`define LU_TAG_W 44

// byte position inside a doubleword
`define LU_OFFSET_W 3

`define LU_TRANS_ID_W 3

`endif

//--- hdl/load_unit_pkg.sv
// ----------------------------------------------------------
// load unit types
// load operation codes and the request controller states
// ----------------------------------------------------------
package load_unit_pkg;

    // load operations understood by the unit
    // the U variants zero-extend, the others sign-extend
    typedef enum logic [2:0] {
        LD,
        LW,
        LWU,
        LH,
        LHU,
        LB,
        LBU
    } load_op_e;

    // states of the request FSM
    // IDLE and SEND_TAG are the two states that may take a new load
    // ABORT_TRANSACTION kills a request after a TLB miss at grant
    // WAIT_TRANSLATION holds the translation request until the TLB hits
    // WAIT_FLUSH kills whatever was outstanding when the flush came in
    typedef enum logic [2:0] {
        IDLE,
        WAIT_GNT,
        SEND_TAG,
        WAIT_PAGE_OFFSET,
        ABORT_TRANSACTION,
        WAIT_TRANSLATION,
        WAIT_FLUSH
    } load_state_e;

endpackage

//--- hdl/load_meta_if.sv
// ----------------------------------------------------------
// load metadata bundle
// carries the metadata of a popped load from the request
// controller to the retire stage and the data aligner
// ----------------------------------------------------------
`include "load_unit_consts.svh"

interface load_meta_if;

    // one-cycle strobe in the cycle the load is popped
    logic                          capture;
    logic [`LU_TRANS_ID_W-1:0]     trans_id;
    logic [`LU_OFFSET_W-1:0]       offset;
    load_unit_pkg::load_op_e       op;
    // high while a response must not retire
    logic                          resp_block;

    // the controller drives everything
    modport ctrl (output capture, trans_id, offset, op, resp_block);

    // retire and align stages only listen
    modport sink (input capture, trans_id, offset, op, resp_block);

endinterface

//--- hdl/load_request_ctrl.sv
// ----------------------------------------------------------
// load request controller
// runs the request FSM towards the data cache and the TLB,
// handles grant wait, page offset stall, TLB miss retry and
// flush, and hands the metadata of popped loads downstream
// ----------------------------------------------------------
`include "load_unit_consts.svh"

module load_request_ctrl (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          flush_i,
    // request side
    input  logic                          valid_i,
    input  logic [`LU_VADDR_W-1:0]        vaddr_i,
    input  logic [`LU_TRANS_ID_W-1:0]     trans_id_i,
    input  load_unit_pkg::load_op_e       op_i,
    output logic                          pop_ld_o,
    // translation side
    output logic                          translation_req_o,
    input  logic [`LU_PADDR_W-1:0]        paddr_i,
    input  logic                          dtlb_hit_i,
    // store buffer address check
    input  logic                          page_offset_match_i,
    // data cache request side
    output logic                          data_req_o,
    input  logic                          data_gnt_i,
    output logic [`LU_INDEX_W-1:0]        address_index_o,
    output logic [`LU_TAG_W-1:0]          address_tag_o,
    output logic [1:0]                    data_size_o,
    output logic                          kill_req_o,
    output logic                          tag_valid_o,
    // metadata towards retire and align
    load_meta_if.ctrl                     meta
);

    load_unit_pkg::load_state_e state_d, state_q;

    // high in the states that can take a fresh load
    logic accept_new;
    // high when a cache request goes out this cycle
    logic issue;

    // log2 of the access size in bytes
    function automatic logic [1:0] transfer_size(input load_unit_pkg::load_op_e op);
        case (op)
            load_unit_pkg::LW, load_unit_pkg::LWU: transfer_size = 2'd2;
            load_unit_pkg::LH, load_unit_pkg::LHU: transfer_size = 2'd1;
            load_unit_pkg::LB, load_unit_pkg::LBU: transfer_size = 2'd0;
            default:                               transfer_size = 2'd3;
        endcase
    endfunction

    // ------------------------------------------------------------
    // address split
    // ------------------------------------------------------------
    // the index is sent in the request cycle straight from the virtual address
    assign address_index_o = vaddr_i[`LU_INDEX_W-1:0];
    // the tag follows a cycle later once the translation is known
    assign address_tag_o   = paddr_i[`LU_PADDR_W-1:`LU_INDEX_W];
    assign data_size_o     = transfer_size(op_i);

    // ------------------------------------------------------------
    // request FSM
    // ------------------------------------------------------------
    assign accept_new = (state_q == load_unit_pkg::IDLE) || (state_q == load_unit_pkg::SEND_TAG);

    // WAIT_GNT keeps the request up, a new load raises it unless a store overlaps
    assign issue = (state_q == load_unit_pkg::WAIT_GNT) ||
                   (accept_new && valid_i && !page_offset_match_i);

    always_comb begin
        state_d           = state_q;
        translation_req_o = 1'b0;
        data_req_o        = 1'b0;
        kill_req_o        = 1'b0;
        tag_valid_o       = 1'b0;
        pop_ld_o          = 1'b0;

        case (state_q)
            load_unit_pkg::WAIT_PAGE_OFFSET: begin
                // retry the request once the older store no longer overlaps
                if (!page_offset_match_i) begin
                    state_d = load_unit_pkg::WAIT_GNT;
                end
            end
            load_unit_pkg::SEND_TAG: begin
                // the translation was a hit at grant so the tag is good
                tag_valid_o = 1'b1;
                state_d     = load_unit_pkg::IDLE;
            end
            load_unit_pkg::ABORT_TRANSACTION: begin
                // free the cache port so the page table walker can get through
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = load_unit_pkg::WAIT_TRANSLATION;
            end
            load_unit_pkg::WAIT_TRANSLATION: begin
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = load_unit_pkg::WAIT_GNT;
                end
            end
            load_unit_pkg::WAIT_FLUSH: begin
                // the cache side only acts on this if a request is outstanding
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = load_unit_pkg::IDLE;
            end
            default: begin
                // IDLE and WAIT_GNT are fully handled by the request decision below
            end
        endcase

        // a new load starts translating right away, even if it has to stall
        if (accept_new && valid_i) begin
            translation_req_o = 1'b1;
            if (page_offset_match_i) begin
                state_d = load_unit_pkg::WAIT_PAGE_OFFSET;
            end
        end

        // shared grant handling for new loads and the grant wait
        if (issue) begin
            translation_req_o = 1'b1;
            data_req_o        = 1'b1;
            if (!data_gnt_i) begin
                state_d = load_unit_pkg::WAIT_GNT;
            end else if (dtlb_hit_i) begin
                state_d  = load_unit_pkg::SEND_TAG;
                pop_ld_o = 1'b1;
            end else begin
                state_d = load_unit_pkg::ABORT_TRANSACTION;
            end
        end

        // a flush always passes through WAIT_FLUSH to kill what is in flight
        if (flush_i) begin
            state_d = load_unit_pkg::WAIT_FLUSH;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= load_unit_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------------------------------------
    // metadata
    // ------------------------------------------------------------
    assign meta.capture    = pop_ld_o;
    assign meta.trans_id   = trans_id_i;
    assign meta.offset     = vaddr_i[`LU_OFFSET_W-1:0];
    assign meta.op         = op_i;
    // responses seen while killing or retranslating belong to a dead request
    assign meta.resp_block = state_q inside {load_unit_pkg::ABORT_TRANSACTION,
                                             load_unit_pkg::WAIT_TRANSLATION,
                                             load_unit_pkg::WAIT_FLUSH};

endmodule

//--- hdl/load_retire.sv
// ----------------------------------------------------------
// load retire stage
// keeps the id of the outstanding load and flags a response
// as valid unless the controller is killing the request
// ----------------------------------------------------------
`include "load_unit_consts.svh"

module load_retire (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          data_rvalid_i,
    load_meta_if.sink                     meta,
    output logic                          valid_o,
    output logic [`LU_TRANS_ID_W-1:0]     trans_id_o
);

    logic [`LU_TRANS_ID_W-1:0] trans_id_q;

    // the id of the popped load is taken in the pop cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            trans_id_q <= '0;
        end else if (meta.capture) begin
            trans_id_q <= meta.trans_id;
        end
    end

    // responses to a killed or flushed request are dropped here
    assign valid_o    = data_rvalid_i && !meta.resp_block;
    assign trans_id_o = trans_id_q;

endmodule

//--- hdl/load_data_align.sv
// ----------------------------------------------------------
// load data aligner
// shifts the returned doubleword down to the accessed bytes
// and zero- or sign-extends it to the full register width
// ----------------------------------------------------------
`include "load_unit_consts.svh"

module load_data_align (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic [`LU_DATA_W-1:0]         data_rdata_i,
    load_meta_if.sink                     meta,
    output logic [`LU_DATA_W-1:0]         result_o
);

    logic [`LU_OFFSET_W-1:0]  offset_q;
    load_unit_pkg::load_op_e  op_q;
    // index of the byte that carries the sign, worked out at capture
    logic [`LU_OFFSET_W-1:0]  idx_d, idx_q;
    logic                     signed_d, signed_q;
    logic [`LU_DATA_W-1:0]    shifted_data;
    // top bit of every byte in the returned doubleword
    logic [7:0]               sign_bits;
    logic                     sign_bit;

    // ------------------------------------------------------------
    // pre-decode at capture
    // ------------------------------------------------------------
    assign signed_d = meta.op inside {load_unit_pkg::LW, load_unit_pkg::LH, load_unit_pkg::LB};

    // a word ends three bytes above its offset, a halfword one byte above
    assign idx_d = (meta.op inside {load_unit_pkg::LW, load_unit_pkg::LWU}) ? meta.offset + 3'd3 :
                   (meta.op inside {load_unit_pkg::LH, load_unit_pkg::LHU}) ? meta.offset + 3'd1 :
                                                                              meta.offset;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            offset_q <= '0;
            op_q     <= load_unit_pkg::LD;
            idx_q    <= '0;
            signed_q <= 1'b0;
        end else if (meta.capture) begin
            offset_q <= meta.offset;
            op_q     <= meta.op;
            idx_q    <= idx_d;
            signed_q <= signed_d;
        end
    end

    // ------------------------------------------------------------
    // realign and extend
    // ------------------------------------------------------------
    assign shifted_data = data_rdata_i >> {offset_q, 3'b000};

    // picking the sign from the unshifted data runs in parallel with the shifter
    assign sign_bits = {data_rdata_i[63], data_rdata_i[55], data_rdata_i[47], data_rdata_i[39],
                        data_rdata_i[31], data_rdata_i[23], data_rdata_i[15], data_rdata_i[7]};

    // unsigned loads pull the fill to zero
    assign sign_bit = signed_q & sign_bits[idx_q];

    always_comb begin
        case (op_q)
            load_unit_pkg::LW, load_unit_pkg::LWU: result_o = {{32{sign_bit}}, shifted_data[31:0]};
            load_unit_pkg::LH, load_unit_pkg::LHU: result_o = {{48{sign_bit}}, shifted_data[15:0]};
            load_unit_pkg::LB, load_unit_pkg::LBU: result_o = {{56{sign_bit}}, shifted_data[7:0]};
            // a doubleword is always aligned and goes out unchanged
            default:                               result_o = shifted_data;
        endcase
    end

endmodule

//--- hdl/load_unit_top.sv
// ----------------------------------------------------------
// load unit
// request controller, retire stage and data aligner joined
// by the load metadata bundle
// ----------------------------------------------------------
`include "load_unit_consts.svh"

module load_unit_top (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          flush_i,
    // load request from issue
    input  logic                          valid_i,
    input  logic [`LU_VADDR_W-1:0]        vaddr_i,
    input  logic [`LU_TRANS_ID_W-1:0]     trans_id_i,
    input  load_unit_pkg::load_op_e       op_i,
    output logic                          pop_ld_o,
    // load result towards writeback
    output logic                          valid_o,
    output logic [`LU_TRANS_ID_W-1:0]     trans_id_o,
    output logic [`LU_DATA_W-1:0]         result_o,
    // address translation
    output logic                          translation_req_o,
    input  logic [`LU_PADDR_W-1:0]        paddr_i,
    input  logic                          dtlb_hit_i,
    // store buffer address check
    input  logic                          page_offset_match_i,
    // data cache port
    output logic                          data_req_o,
    input  logic                          data_gnt_i,
    output logic [`LU_INDEX_W-1:0]        address_index_o,
    output logic [`LU_TAG_W-1:0]          address_tag_o,
    output logic [1:0]                    data_size_o,
    output logic                          kill_req_o,
    output logic                          tag_valid_o,
    input  logic                          data_rvalid_i,
    input  logic [`LU_DATA_W-1:0]         data_rdata_i
);

    load_meta_if meta_if_i ();

    load_request_ctrl ctrl_i (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .valid_i             (valid_i),
        .vaddr_i             (vaddr_i),
        .trans_id_i          (trans_id_i),
        .op_i                (op_i),
        .pop_ld_o            (pop_ld_o),
        .translation_req_o   (translation_req_o),
        .paddr_i             (paddr_i),
        .dtlb_hit_i          (dtlb_hit_i),
        .page_offset_match_i (page_offset_match_i),
        .data_req_o          (data_req_o),
        .data_gnt_i          (data_gnt_i),
        .address_index_o     (address_index_o),
        .address_tag_o       (address_tag_o),
        .data_size_o         (data_size_o),
        .kill_req_o          (kill_req_o),
        .tag_valid_o         (tag_valid_o),
        .meta                (meta_if_i.ctrl)
    );

    load_retire retire_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .data_rvalid_i (data_rvalid_i),
        .meta          (meta_if_i.sink),
        .valid_o       (valid_o),
        .trans_id_o    (trans_id_o)
    );

    load_data_align align_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .data_rdata_i (data_rdata_i),
        .meta         (meta_if_i.sink),
        .result_o     (result_o)
    );

endmodule

//--- testbench/tb_load_unit.sv
// ----------------------------------------------------------
// load unit testbench
// replays the load cases against the DUT with a cache
// responder, a TLB model and per-cycle protocol checks
// ----------------------------------------------------------
`include "load_unit_consts.svh"

module tb_load_unit;

    localparam int MAX_CASES = 32;
    localparam int LIMIT     = 60;

    logic                      clk_i, rst_ni, flush_i, valid_i, pop_ld_o, valid_o;
    logic [`LU_VADDR_W-1:0]    vaddr_i;
    logic [`LU_TRANS_ID_W-1:0] trans_id_i, trans_id_o;
    load_unit_pkg::load_op_e   op_i;
    logic [`LU_DATA_W-1:0]     result_o, data_rdata_i;
    logic                      translation_req_o, dtlb_hit_i, page_offset_match_i;
    logic [`LU_PADDR_W-1:0]    paddr_i;
    logic                      data_req_o, data_gnt_i, kill_req_o, tag_valid_o, data_rvalid_i;
    logic [`LU_INDEX_W-1:0]    address_index_o;
    logic [`LU_TAG_W-1:0]      address_tag_o;
    logic [1:0]                data_size_o;

    // ------------------------------------------------------------
    // case table, one entry per line of the cases file
    // ------------------------------------------------------------
    string       name_a [MAX_CASES];
    logic [2:0]  op_a [MAX_CASES];
    logic [2:0]  off_a [MAX_CASES];
    int          id_a [MAX_CASES];
    int          gnt_a [MAX_CASES];
    int          match_a [MAX_CASES];
    int          miss_a [MAX_CASES];
    int          flush_a [MAX_CASES];
    int          pipe_a [MAX_CASES];
    logic [63:0] paddr_a [MAX_CASES];
    logic [63:0] data_a [MAX_CASES];
    logic [63:0] exp_a [MAX_CASES];
    int          n_cases;

    // responses owed by the cache model, in tag order, with their delays
    int     case_q [$];
    int     dly_q [$];
    int     inflight, rsp_case, tag_case, cur_case, errors, checks;
    bit     tag_due, hung;
    integer seed;

    load_unit_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic report_fault(input string nm, input string what);
        $display("%s: %s", nm, what);
        errors++;
    endtask

    task automatic report_value(input string nm, input string what,
                                input logic [63:0] exp, input logic [63:0] act);
        $display("ERROR %s: %s expected %h actual %h", nm, what, exp, act);
        errors++;
    endtask

    // log2 of the access width in bytes
    function automatic logic [1:0] expected_size(input logic [2:0] op);
        if (op == 3'd0) return 2'd3;
        if (op <= 3'd2) return 2'd2;
        if (op <= 3'd4) return 2'd1;
        return 2'd0;
    endfunction

    task automatic load_cases();
        int          fd, cnt, op, off, id, g, m, x, f, p;
        logic [63:0] pa, d, e;
        string       line, nm;
        fd = $fopen("testbench/load_cases.txt", "r");
        if (fd == 0) begin
            report_fault("setup", "could not open testbench/load_cases.txt");
        end else begin
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                cnt = $fgets(line, fd);
                if (cnt > 1 && line[0] != "#") begin
                    cnt = $sscanf(line, "%s %d %d %d %h %d %d %d %d %d %h %h",
                                  nm, op, off, id, pa, g, m, x, f, p, d, e);
                    if (cnt != 12) begin
                        report_fault("setup", "malformed line in the cases file");
                    end else begin
                        name_a[n_cases]  = nm;
                        op_a[n_cases]    = op;
                        off_a[n_cases]   = off;
                        id_a[n_cases]    = id;
                        paddr_a[n_cases] = pa;
                        gnt_a[n_cases]   = g;
                        match_a[n_cases] = m;
                        miss_a[n_cases]  = x;
                        flush_a[n_cases] = f;
                        pipe_a[n_cases]  = p;
                        data_a[n_cases]  = d;
                        exp_a[n_cases]   = e;
                        n_cases++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------------------------------------
    // request driver, runs one load up to its pop
    // ------------------------------------------------------------
    task automatic run_case(input int k);
        int                     cyc, gnt_left, match_left, miss_left;
        bit                     popped, req_seen, abort_next, in_xlat, fast;
        logic [`LU_VADDR_W-1:0] va;
        gnt_left   = gnt_a[k];
        match_left = match_a[k];
        miss_left  = miss_a[k];
        fast       = !pipe_a[k] && gnt_left == 0 && match_left == 0 && miss_left == 0;
        popped     = 1'b0;
        req_seen   = 1'b0;
        abort_next = 1'b0;
        in_xlat    = 1'b0;
        cyc        = 0;
        va         = {8'h00, paddr_a[k][55:3], off_a[k]};
        while (!popped && !hung) begin
            @(negedge clk_i);
            cur_case            = k;
            valid_i             = 1'b1;
            vaddr_i             = va;
            trans_id_i          = id_a[k];
            op_i                = load_unit_pkg::load_op_e'(op_a[k]);
            // the physical address lags the request by a cycle, so the tag cycle
            // of the previous load still carries that load's address
            if (cyc == 0 && pipe_a[k] && k > 0) begin
                paddr_i = paddr_a[k - 1][55:0];
            end else begin
                paddr_i = paddr_a[k][55:0];
            end
            page_offset_match_i = (match_left > 0);
            dtlb_hit_i          = (miss_left == 0);
            // the cache model holds the grant while an older load still owes data
            data_gnt_i          = (gnt_left == 0) && (inflight == 0);
            @(posedge clk_i);
            checks++;
            if (cyc == 0 && pipe_a[k] && !(data_req_o && tag_valid_o)) begin
                report_fault(name_a[k], "not requested in the tag cycle of the previous load");
            end
            if (cyc == 0 && fast && !(pop_ld_o && data_req_o)) begin
                report_fault(name_a[k], "fast path load was not popped in its first cycle");
            end
            if (abort_next) begin
                if (!(kill_req_o && tag_valid_o)) begin
                    report_fault(name_a[k], "no kill with tag valid after the TLB miss");
                end
                abort_next = 1'b0;
                in_xlat    = 1'b1;
            end else if (in_xlat) begin
                if (!translation_req_o || data_req_o) begin
                    report_fault(name_a[k], "translation request not held until the TLB hit");
                end
                if (dtlb_hit_i) in_xlat = 1'b0;
                else miss_left--;
            end else if (req_seen && !data_req_o) begin
                report_fault(name_a[k], "data_req_o dropped before the grant");
            end
            if (page_offset_match_i && (data_req_o || pop_ld_o)) begin
                report_fault(name_a[k], "request issued while the page offset matched");
            end
            if (data_req_o) req_seen = 1'b1;
            if (data_req_o && data_gnt_i && !dtlb_hit_i) abort_next = 1'b1;
            if (data_req_o && gnt_left > 0) gnt_left--;
            if (match_left > 0) match_left--;
            if (pop_ld_o) begin
                popped = 1'b1;
                if (!(data_req_o && data_gnt_i && dtlb_hit_i)) begin
                    report_fault(name_a[k], "pop without a granted and translated request");
                end
                if (address_index_o !== va[11:0]) begin
                    report_value(name_a[k], "address_index_o", va[11:0], address_index_o);
                end
                if (data_size_o !== expected_size(op_a[k])) begin
                    report_value(name_a[k], "data_size_o", expected_size(op_a[k]), data_size_o);
                end
            end
            cyc++;
            if (cyc > LIMIT && !popped) begin
                report_fault(name_a[k], "timed out waiting for pop_ld_o");
                hung = 1'b1;
            end
        end
    endtask

    task automatic wait_idle();
        int cnt;
        cnt = 0;
        while ((inflight != 0 || case_q.size() != 0) && cnt < LIMIT) begin
            @(negedge clk_i);
            cnt++;
        end
        if (inflight != 0 || case_q.size() != 0) begin
            report_fault("drain", "timed out waiting for outstanding loads to return");
            hung = 1'b1;
        end
    endtask

    // drops the request in the tag cycle, optionally flushing there
    task automatic close_case(input int k);
        @(negedge clk_i);
        valid_i    = 1'b0;
        data_gnt_i = 1'b0;
        flush_i    = flush_a[k];
        @(negedge clk_i);
        if (flush_a[k]) begin
            checks++;
            if (!(kill_req_o && tag_valid_o)) report_fault(name_a[k], "no kill after the flush");
        end
        flush_i = 1'b0;
        wait_idle();
    endtask

    // ------------------------------------------------------------
    // cache responder, returns data in tag order after a delay
    // ------------------------------------------------------------
    always @(negedge clk_i) begin
        data_rvalid_i = 1'b0;
        if (case_q.size() > 0) begin
            if (dly_q[0] == 0) begin
                rsp_case      = case_q.pop_front();
                dly_q.delete(0);
                data_rvalid_i = 1'b1;
                data_rdata_i  = data_a[rsp_case];
            end else begin
                dly_q[0] = dly_q[0] - 1;
            end
        end
    end

    // tag timing and response checks, sampled at the rising edge
    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (tag_due) begin
                checks++;
                if (!tag_valid_o || kill_req_o) begin
                    report_fault(name_a[tag_case], "no tag_valid_o one cycle after the grant");
                end
                if (address_tag_o !== paddr_a[tag_case][55:12]) begin
                    report_value(name_a[tag_case], "address_tag_o",
                                 paddr_a[tag_case][55:12], address_tag_o);
                end
                case_q.push_back(tag_case);
                // a flushed load answers right in the WAIT_FLUSH cycle
                dly_q.push_back(flush_a[tag_case] ? 0 : $unsigned($random(seed)) % 4);
            end
            tag_due  = pop_ld_o;
            tag_case = cur_case;
            if (pop_ld_o) inflight++;
            if (valid_o && !data_rvalid_i) report_fault("dut", "valid_o without a cache response");
            if (data_rvalid_i) begin
                inflight--;
                checks++;
                if (flush_a[rsp_case]) begin
                    if (valid_o) report_fault(name_a[rsp_case], "valid_o for a flushed load");
                end else if (!valid_o) begin
                    report_fault(name_a[rsp_case], "response did not raise valid_o");
                end else begin
                    if (trans_id_o !== id_a[rsp_case][2:0]) begin
                        report_value(name_a[rsp_case], "trans_id_o", id_a[rsp_case], trans_id_o);
                    end
                    if (result_o !== exp_a[rsp_case]) begin
                        report_value(name_a[rsp_case], "result_o", exp_a[rsp_case], result_o);
                    end
                end
            end
        end
    end

    initial begin
        seed                = 32'h4f83;
        errors              = 0;
        checks              = 0;
        n_cases             = 0;
        inflight            = 0;
        cur_case            = 0;
        tag_case            = 0;
        rsp_case            = 0;
        tag_due             = 1'b0;
        hung                = 1'b0;
        rst_ni              = 1'b0;
        flush_i             = 1'b0;
        valid_i             = 1'b0;
        vaddr_i             = '0;
        trans_id_i          = '0;
        op_i                = load_unit_pkg::LD;
        paddr_i             = '0;
        dtlb_hit_i          = 1'b0;
        page_offset_match_i = 1'b0;
        data_gnt_i          = 1'b0;
        data_rvalid_i       = 1'b0;
        data_rdata_i        = '0;
        load_cases();
        repeat (2) @(negedge clk_i);
        // the reset state is sampled before the first clock can move the FSM on
        checks++;
        if (data_req_o || tag_valid_o || kill_req_o || translation_req_o || pop_ld_o || valid_o) begin
            report_fault("reset", "control outputs not low after reset");
        end
        rst_ni = 1'b1;
        for (int k = 0; k < n_cases && !hung; k++) begin
            run_case(k);
            // a piped load is driven in the tag cycle of this one
            if (hung || (k + 1 < n_cases && pipe_a[k + 1])) continue;
            close_case(k);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- testbench/load_cases.txt
# name op(0=LD 1=LW 2=LWU 3=LH 4=LHU 5=LB 6=LBU) offset id paddr(hex)
# gnt_delay match_cycles miss_cycles flush pipe rdata(hex) expected(hex)
ld_fast      0 0 1 00a1b2c3d4e5f000 0 0 0 0 0 8899aabbccddeeff 8899aabbccddeeff
lw_neg       1 4 2 00a1b2c3d4e5f008 0 0 0 0 0 8899aabbccddeeff ffffffff8899aabb
lwu          2 4 3 0000123456789010 0 0 0 0 0 8899aabbccddeeff 000000008899aabb
lw_pos       1 4 4 00fedcba98765018 0 0 0 0 0 0123456789abcdef 0000000001234567
lh_neg       3 2 5 0011223344556020 0 0 0 0 0 8899aabbccddeeff ffffffffffffccdd
lhu          4 6 6 00778899aabbc028 0 0 0 0 0 8899aabbccddeeff 0000000000008899
lb_neg       5 5 7 0055aa55aa55a030 0 0 0 0 0 8899aabbccddeeff ffffffffffffffaa
lbu          6 1 0 00000000000ff038 0 0 0 0 0 8899aabbccddeeff 00000000000000ee
lb_pos       5 7 1 0012345678000040 0 0 0 0 0 0123456789abcdef 0000000000000001
gnt_delay    1 0 2 00c0ffee00001048 3 0 0 0 0 0123456789abcdef ffffffff89abcdef
page_match   3 0 3 00beef0000002050 0 3 0 0 0 0123456789abcdef ffffffffffffcdef
tlb_miss     0 0 4 0033445566773058 0 0 2 0 0 0f0e0d0c0b0a0908 0f0e0d0c0b0a0908
all_stalls   4 2 5 0066554433224060 2 2 1 0 0 0123456789abcdef 00000000000089ab
flush_tag    0 0 6 00abcdef01235068 0 0 0 1 0 deadbeefdeadbeef 0000000000000000
after_flush  5 3 7 00abcdef01236070 0 0 0 0 0 8899aabbccddeeff ffffffffffffffcc
pipe_first   2 0 6 0099887766557078 0 0 0 0 0 0123456789abcdef 0000000089abcdef
pipe_second  6 6 7 0099887766558080 0 0 0 0 1 8899aabbccddeeff 0000000000000099

//--- files.f
+incdir+hdl
hdl/load_unit_pkg.sv
hdl/load_meta_if.sv
hdl/load_request_ctrl.sv
hdl/load_retire.sv
hdl/load_data_align.sv
hdl/load_unit_top.sv
testbench/tb_load_unit.sv
